// ==== logic/vga_timing_pkg.sv ====
// Only the 640x480 60 Hz raster is described here; active area first, both syncs active low
package vga_timing_pkg;

    // -------------------------------------------------------------------
    // Coordinate width
    // -------------------------------------------------------------------
    // Wide enough for the horizontal total of 800
    localparam int coord_w = 10;

    // -------------------------------------------------------------------
    // Horizontal raster in pixel clocks
    // -------------------------------------------------------------------
    localparam logic [coord_w-1:0] h_disp  = 10'd640;
    localparam logic [coord_w-1:0] h_front = 10'd16;
    localparam logic [coord_w-1:0] h_sync  = 10'd96;
    localparam logic [coord_w-1:0] h_back  = 10'd48;
    localparam logic [coord_w-1:0] h_total = h_disp + h_front + h_sync + h_back;

    // Sync is low for h_sync_start <= h < h_sync_end
    localparam logic [coord_w-1:0] h_sync_start = h_disp + h_front;
    localparam logic [coord_w-1:0] h_sync_end   = h_sync_start + h_sync;

    // -------------------------------------------------------------------
    // Vertical raster in lines
    // -------------------------------------------------------------------
    localparam logic [coord_w-1:0] v_disp  = 10'd480;
    localparam logic [coord_w-1:0] v_front = 10'd10;
    localparam logic [coord_w-1:0] v_sync  = 10'd2;
    localparam logic [coord_w-1:0] v_back  = 10'd33;
    localparam logic [coord_w-1:0] v_total = v_disp + v_front + v_sync + v_back;

    localparam logic [coord_w-1:0] v_sync_start = v_disp + v_front;
    localparam logic [coord_w-1:0] v_sync_end   = v_sync_start + v_sync;

    // Pixel position inside the active area
    typedef struct packed {
        logic [coord_w-1:0] x;
        logic [coord_w-1:0] y;
    } vga_coord_t;

    // Per-cycle raster timing
    typedef struct packed {
        logic hsync;    // active low
        logic vsync;    // active low
        logic de;
    } vga_raster_t;

    // Idle state of the timing flags, also the reset value downstream
    localparam vga_raster_t raster_idle = '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};

endpackage

// ==== logic/vga_color_pkg.sv ====
// RGB565 pixel word and RGB888 pin colour only; field order is r in the top bits, b at the bottom
package vga_color_pkg;

    // -------------------------------------------------------------------
    // Channel widths
    // -------------------------------------------------------------------
    localparam int r_w    = 5;
    localparam int g_w    = 6;
    localparam int b_w    = 5;
    localparam int pix_w  = r_w + g_w + b_w;
    // Width of one output channel on the pins
    localparam int chan_w = 8;

    // Channel view of an RGB565 word
    typedef struct packed {
        logic [r_w-1:0] r;
        logic [g_w-1:0] g;
        logic [b_w-1:0] b;
    } rgb565_fields_t;

    // One pixel word, read whole or per channel
    typedef union packed {
        logic [pix_w-1:0] raw;
        rgb565_fields_t   fields;
    } rgb565_t;

    // Colour as driven onto the VGA pins
    typedef struct packed {
        logic [chan_w-1:0] r;
        logic [chan_w-1:0] g;
        logic [chan_w-1:0] b;
    } rgb888_t;

endpackage

// ==== logic/vga_timing.sv ====
// Fixed 640x480 raster; counters restart at pixel (0, 0) on reset release, coord is zero in blanking
`timescale 1ns/100ps

module vga_timing (
    input  logic                        vga_clk,
    input  logic                        sys_rst_n,
    output vga_timing_pkg::vga_coord_t  coord,
    output vga_timing_pkg::vga_raster_t raster
);
    import vga_timing_pkg::*;

    // Raster position counters
    logic [coord_w-1:0] h_cnt;
    logic [coord_w-1:0] v_cnt;

    // Wrap points
    logic line_end;
    logic frame_end;

    // Inside the display area per axis
    logic h_act;
    logic v_act;

    // Sync windows
    logic h_in_sync;
    logic v_in_sync;

    // -------------------------------------------------------------------
    // Counters
    // -------------------------------------------------------------------
    // Last pixel clock of a line
    assign line_end  = (h_cnt == h_total - 1'b1);
    // Last line of a frame
    assign frame_end = (v_cnt == v_total - 1'b1);

    // Horizontal counter runs every clock
    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            h_cnt <= '0;
        end else if (line_end) begin
            h_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Vertical counter steps once per line
    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            v_cnt <= '0;
        end else if (line_end) begin
            if (frame_end) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end
    end

    // -------------------------------------------------------------------
    // Decode of the counter position
    // -------------------------------------------------------------------
    // Active area comes first in each line and frame
    assign h_act = (h_cnt < h_disp);
    assign v_act = (v_cnt < v_disp);

    // After the front porch, before the back porch
    assign h_in_sync = (h_cnt >= h_sync_start) && (h_cnt < h_sync_end);
    assign v_in_sync = (v_cnt >= v_sync_start) && (v_cnt < v_sync_end);

    // Timing flags straight from the counters, same cycle
    always_comb begin
        raster.hsync = ~h_in_sync;
        raster.vsync = ~v_in_sync;
        raster.de    = h_act & v_act;
    end

    // Coordinate follows the counters only while de is high
    always_comb begin
        if (h_act && v_act) begin
            coord.x = h_cnt;
            coord.y = v_cnt;
        end else begin
            coord.x = '0;
            coord.y = '0;
        end
    end

endmodule

// ==== logic/vga_display.sv ====
// Colour bars only: red follows x, green follows y, blue fixed full; pixel lags coord by one clock
`timescale 1ns/100ps

module vga_display (
    input  logic                       vga_clk,
    input  logic                       sys_rst_n,
    input  vga_timing_pkg::vga_coord_t coord,
    output vga_color_pkg::rgb565_t     pixel
);
    import vga_color_pkg::*;

    // 8-bit channel values before truncation
    logic [chan_w-1:0] red8;
    logic [chan_w-1:0] grn8;

    // -------------------------------------------------------------------
    // Pattern rule
    // -------------------------------------------------------------------
    // Low byte of x ramps red across the line
    assign red8 = coord.x[chan_w-1:0];

    // Low byte of y ramps green down the frame
    assign grn8 = coord.y[chan_w-1:0];

    // -------------------------------------------------------------------
    // Pixel register
    // -------------------------------------------------------------------
    // Keep the top bits of each channel for RGB565
    // Blanking happens downstream, so coord of zero still gives full blue here
    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            pixel <= '0;
        end else begin
            // Top 5 of red
            pixel.fields.r <= red8[chan_w-1 -: r_w];
            // Top 6 of green
            pixel.fields.g <= grn8[chan_w-1 -: g_w];
            // Blue stays at full scale
            pixel.fields.b <= '1;
        end
    end

endmodule

// ==== logic/vga_pixel_pipe.sv ====
// One register stage matching the display latency; the raster is held idle while in reset
`timescale 1ns/100ps

module vga_pixel_pipe (
    input  logic                        vga_clk,
    input  logic                        sys_rst_n,
    input  vga_timing_pkg::vga_raster_t raster,
    output vga_timing_pkg::vga_raster_t raster_dly
);
    import vga_timing_pkg::*;

    // -------------------------------------------------------------------
    // Timing delay
    // -------------------------------------------------------------------
    // The display registers its pixel once, so the syncs and de
    // need exactly one stage here to arrive with that pixel

    // Idle raster on reset
    // syncs high, de low
    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            raster_dly <= raster_idle;
        end else begin
            // Whole struct moves together
            raster_dly <= raster;
        end
    end

endmodule

// ==== logic/vga_out.sv ====
// Pins are registered; colour is forced to black whenever the delayed de is low
`timescale 1ns/100ps

module vga_out (
    input  logic                        vga_clk,
    input  logic                        sys_rst_n,
    input  vga_timing_pkg::vga_raster_t raster_dly,
    input  vga_color_pkg::rgb565_t      pixel,
    output logic                        hsync,
    output logic                        vsync,
    output logic                        de,
    output vga_color_pkg::rgb888_t      rgb
);
    import vga_timing_pkg::*;
    import vga_color_pkg::*;

    // Expanded colour
    rgb888_t rgb_exp;
    // After blanking
    rgb888_t rgb_nxt;

    // -------------------------------------------------------------------
    // RGB565 to RGB888
    // -------------------------------------------------------------------
    // Repeat the top bits into the low bits so full scale maps to 255
    assign rgb_exp.r = {pixel.fields.r, pixel.fields.r[r_w-1 -: chan_w-r_w]};
    assign rgb_exp.g = {pixel.fields.g, pixel.fields.g[g_w-1 -: chan_w-g_w]};
    assign rgb_exp.b = {pixel.fields.b, pixel.fields.b[b_w-1 -: chan_w-b_w]};

    // Black outside the active area
    assign rgb_nxt = raster_dly.de ? rgb_exp : '0;

    // -------------------------------------------------------------------
    // Pin registers
    // -------------------------------------------------------------------
    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            // Syncs inactive and screen dark
            hsync <= raster_idle.hsync;
            vsync <= raster_idle.vsync;
            de    <= raster_idle.de;
            rgb   <= '0;
        end else begin
            hsync <= raster_dly.hsync;
            vsync <= raster_dly.vsync;
            de    <= raster_dly.de;
            rgb   <= rgb_nxt;
        end
    end

endmodule

// ==== logic/vga_colorbar_top.sv ====
// vga_clk is supplied from outside; pins describe the raster position from two clocks earlier
`timescale 1ns/100ps

module vga_colorbar_top (
    input  logic                   vga_clk,
    input  logic                   sys_rst_n,
    output logic                   hsync,
    output logic                   vsync,
    output logic                   de,
    output vga_color_pkg::rgb888_t rgb
);
    import vga_timing_pkg::*;
    import vga_color_pkg::*;

    // Timing generator outputs
    vga_coord_t  coord;
    vga_raster_t raster;

    // One clock later
    vga_raster_t raster_dly;
    rgb565_t     pixel;

    // -------------------------------------------------------------------
    // Raster source
    // -------------------------------------------------------------------
    vga_timing u_timing (
        .vga_clk   (vga_clk),
        .sys_rst_n (sys_rst_n),
        .coord     (coord),
        .raster    (raster)
    );

    // Pattern beside the timing delay
    vga_display u_display (
        .vga_clk   (vga_clk),
        .sys_rst_n (sys_rst_n),
        .coord     (coord),
        .pixel     (pixel)
    );

    vga_pixel_pipe u_pipe (
        .vga_clk    (vga_clk),
        .sys_rst_n  (sys_rst_n),
        .raster     (raster),
        .raster_dly (raster_dly)
    );

    // -------------------------------------------------------------------
    // Pin stage
    // -------------------------------------------------------------------
    vga_out u_out (
        .vga_clk    (vga_clk),
        .sys_rst_n  (sys_rst_n),
        .raster_dly (raster_dly),
        .pixel      (pixel),
        .hsync      (hsync),
        .vsync      (vsync),
        .de         (de),
        .rgb        (rgb)
    );

endmodule

// ==== dv/vga_colorbar_asserts.sv ====
// Bound into vga_out; all checks are off while sys_rst_n is low and resume on release
`timescale 1ns/100ps

module vga_colorbar_asserts (
    input logic                        vga_clk,
    input logic                        sys_rst_n,
    input vga_timing_pkg::vga_raster_t raster_dly,
    input vga_color_pkg::rgb565_t      pixel,
    input logic                        hsync,
    input logic                        vsync,
    input logic                        de,
    input vga_color_pkg::rgb888_t      rgb
);

    // -------------------------------------------------------------------
    // Sync and blanking
    // -------------------------------------------------------------------
    // Sync windows lie outside the active area and stay black
    sync_dark_a: assert property (@(posedge vga_clk) disable iff (!sys_rst_n)
        (!hsync || !vsync) |-> (!de && rgb == '0))
        else $error("sync active while de is high or rgb is not black");

    // Full blue on every active pixel
    blue_full_a: assert property (@(posedge vga_clk) disable iff (!sys_rst_n)
        de |-> (rgb.b == 8'hff))
        else $error("blue channel not full in the active area");

    // -------------------------------------------------------------------
    // Pixel alignment
    // -------------------------------------------------------------------
    // Display word beside an active raster is never the cleared word
    active_word_a: assert property (@(posedge vga_clk) disable iff (!sys_rst_n)
        raster_dly.de |-> (pixel.raw != '0))
        else $error("cleared RGB565 word beside an active delayed raster");

endmodule

// ==== dv/vga_colorbar_tb.sv ====
// Needs a 10 ns vga_clk; position is rebuilt from the pins alone, each probe waits up to one frame
`timescale 1ns/100ps

module vga_colorbar_tb;
    import vga_color_pkg::*;

    // -------------------------------------------------------------------
    // Raster numbers for 640x480 at 60 Hz
    // -------------------------------------------------------------------
    localparam int line_cycles  = 800;
    localparam int act_cycles   = 640;
    localparam int hsync_cycles = 96;
    localparam int act_lines    = 480;
    localparam int vsync_cycles = 2 * line_cycles;
    localparam int frame_cycles = 525 * line_cycles;
    localparam int rst_cycles   = 16;

    // Probe table size
    localparam int n_fixed = 12;
    localparam int n_rand  = 4;
    localparam int n_probe = n_fixed + n_rand;

    // Corners, red and green bar edges, mid-screen
    localparam int fixed_x [n_fixed] = '{0, 639, 0, 639, 7, 8, 255, 256, 320, 100, 4, 511};
    localparam int fixed_y [n_fixed] = '{0, 0, 479, 479, 0, 0, 10, 10, 240, 3, 252, 256};

    // One probe with its expected pin colour
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        rgb888_t    exp_rgb;
    } probe_t;

    // Pin sample plus the tracked position
    typedef struct packed {
        logic       hs;
        logic       vs;
        logic       de;
        logic [9:0] x;
        logic [9:0] y;
        rgb888_t    rgb;
    } sample_t;

    logic    vga_clk = 1'b0;
    logic    sys_rst_n = 1'b0;
    logic    hsync;
    logic    vsync;
    logic    de;
    rgb888_t rgb;

    probe_t  probes [n_probe];
    sample_t cur;
    sample_t trk;
    int      x_cnt;
    int      line_cnt;
    logic    prev_de;
    int      err_cnt;
    integer  seed;
    int      i;
    int      period;
    int      low;
    int      act;
    int      lines;

    vga_colorbar_top dut_i (
        .vga_clk   (vga_clk),
        .sys_rst_n (sys_rst_n),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de),
        .rgb       (rgb)
    );

    bind vga_out vga_colorbar_asserts u_asserts (
        .vga_clk    (vga_clk),
        .sys_rst_n  (sys_rst_n),
        .raster_dly (raster_dly),
        .pixel      (pixel),
        .hsync      (hsync),
        .vsync      (vsync),
        .de         (de),
        .rgb        (rgb)
    );

    initial begin
        forever #5 vga_clk = ~vga_clk;
    end

    // -------------------------------------------------------------------
    // Reference model and reporting
    // -------------------------------------------------------------------
    // Top bits of the low byte, then the top bits repeated below
    function automatic rgb888_t expected_rgb(input logic [9:0] x, input logic [9:0] y);
        logic [4:0] r5;
        logic [5:0] g6;
        logic [4:0] b5;
        rgb888_t    c;
        r5 = x[7:3];
        g6 = y[7:2];
        b5 = 5'd31;
        c.r = 8'(r5) * 8'd8 + 8'(r5 >> 2);
        c.g = 8'(g6) * 8'd4 + 8'(g6 >> 4);
        c.b = 8'(b5) * 8'd8 + 8'(b5 >> 2);
        return c;
    endfunction

    function automatic logic is_idle(input sample_t s);
        return s.hs && s.vs && !s.de && (s.rgb == '0);
    endfunction

    task automatic stop_run;
        $display("Test failures found");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic value_error(input string msg);
        err_cnt++;
        $display("ERROR at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic timed_out(input string what);
        $display("Timed out waiting for %s", what);
        stop_run();
    endtask

    // -------------------------------------------------------------------
    // Raster tracker sampling the pins mid-cycle
    // -------------------------------------------------------------------
    always @(negedge vga_clk) begin
        if (!sys_rst_n) begin
            x_cnt    = 0;
            line_cnt = 0;
            prev_de  = 1'b0;
        end else begin
            // Vsync pulse restarts the line count
            if (!vsync) begin
                line_cnt = 0;
            end else if (prev_de && !de) begin
                line_cnt = line_cnt + 1;
            end
            if (!de) begin
                x_cnt = 0;
            end
        end
        cur.hs  = hsync;
        cur.vs  = vsync;
        cur.de  = de;
        cur.x   = 10'(x_cnt);
        cur.y   = 10'(line_cnt);
        cur.rgb = rgb;
        if (de) begin
            x_cnt = x_cnt + 1;
        end
        prev_de = de;
        if (!sys_rst_n) begin
            assert (is_idle(cur)) else value_error("outputs not idle during reset");
        end else if (!de) begin
            assert (rgb == '0) else value_error($sformatf("rgb %h while de is low", rgb));
        end
        // Published for readers on the rising edge
        trk <= cur;
    end

    // -------------------------------------------------------------------
    // Bounded waits
    // -------------------------------------------------------------------
    task automatic wait_pos(input logic [9:0] x, input logic [9:0] y);
        logic found;
        int   n;
        found = 1'b0;
        for (n = 0; n < frame_cycles + line_cycles && !found; n++) begin
            @(posedge vga_clk);
            found = trk.de && (trk.x == x) && (trk.y == y);
        end
        if (!found) timed_out($sformatf("pixel (%0d, %0d)", x, y));
    endtask

    task automatic wait_fall(input logic use_vs, input int limit);
        logic last;
        logic now_s;
        logic found;
        int   n;
        last  = 1'b0;
        found = 1'b0;
        for (n = 0; n < limit && !found; n++) begin
            @(posedge vga_clk);
            now_s = use_vs ? trk.vs : trk.hs;
            found = last && !now_s;
            last  = now_s;
        end
        if (!found) timed_out(use_vs ? "a vsync falling edge" : "an hsync falling edge");
    endtask

    // Period, low cycles, de cycles and de runs from one fall to the next
    task automatic measure_sync(input logic use_vs, input int limit, output int per,
                                output int lo, output int ac, output int ln);
        logic last_s;
        logic last_de;
        logic s;
        int   n;
        wait_fall(use_vs, limit);
        per     = 0;
        lo      = 1;
        ac      = 0;
        ln      = 0;
        last_s  = 1'b0;
        last_de = trk.de;
        for (n = 1; n <= limit && per == 0; n++) begin
            @(posedge vga_clk);
            s = use_vs ? trk.vs : trk.hs;
            if (last_s && !s) begin
                per = n;
            end else begin
                if (!s) lo++;
                if (trk.de) ac++;
                if (!last_de && trk.de) ln++;
                last_s  = s;
                last_de = trk.de;
            end
        end
        if (per == 0) timed_out("the next sync falling edge");
    endtask

    // Reset, then idle around release and pixel (0, 0) right after
    task automatic apply_reset;
        int n;
        @(negedge vga_clk);
        sys_rst_n <= 1'b0;
        for (n = 0; n < rst_cycles; n++) begin
            @(negedge vga_clk);
        end
        sys_rst_n <= 1'b1;
        for (n = 0; n < 2; n++) begin
            @(posedge vga_clk);
            assert (is_idle(trk)) else value_error("outputs not idle at reset release");
        end
        @(posedge vga_clk);
        assert (trk.de && trk.x == '0 && trk.y == '0 && trk.rgb == expected_rgb(10'd0, 10'd0))
            else value_error($sformatf("first pixel de %b rgb %h", trk.de, trk.rgb));
    endtask

    // -------------------------------------------------------------------
    // Sequence
    // -------------------------------------------------------------------
    initial begin
        err_cnt = 0;
        seed    = 32'he5d8_cdd1;
        // Probe table with fixed points first and random ones after
        for (i = 0; i < n_probe; i++) begin
            if (i < n_fixed) begin
                probes[i].x = 10'(fixed_x[i]);
                probes[i].y = 10'(fixed_y[i]);
            end else begin
                probes[i].x = 10'(($random(seed) & 32'h7fff_ffff) % act_cycles);
                probes[i].y = 10'(($random(seed) & 32'h7fff_ffff) % act_lines);
            end
            probes[i].exp_rgb = expected_rgb(probes[i].x, probes[i].y);
        end

        apply_reset();

        // Line structure
        measure_sync(1'b0, 2 * line_cycles, period, low, act, lines);
        assert (period == line_cycles) else value_error($sformatf("hsync period %0d", period));
        assert (low == hsync_cycles) else value_error($sformatf("hsync low for %0d", low));
        assert (act == act_cycles) else value_error($sformatf("de high for %0d", act));
        assert (lines == 1) else value_error($sformatf("de split into %0d runs", lines));

        // Frame structure
        measure_sync(1'b1, frame_cycles + line_cycles, period, low, act, lines);
        assert (period == frame_cycles) else value_error($sformatf("vsync period %0d", period));
        assert (low == vsync_cycles) else value_error($sformatf("vsync low for %0d", low));
        assert (lines == act_lines) else value_error($sformatf("%0d active lines", lines));

        // Colour probes
        for (i = 0; i < n_probe; i++) begin
            wait_pos(probes[i].x, probes[i].y);
            assert (trk.rgb == probes[i].exp_rgb)
                else value_error($sformatf("rgb %h at (%0d, %0d), expected %h", trk.rgb,
                                           probes[i].x, probes[i].y, probes[i].exp_rgb));
        end

        // Reset in the middle of a frame
        wait_pos(10'd200, 10'd300);
        apply_reset();
        measure_sync(1'b0, 2 * line_cycles, period, low, act, lines);
        assert (period == line_cycles) else value_error($sformatf("hsync period %0d", period));
        wait_pos(probes[8].x, probes[8].y);
        assert (trk.rgb == probes[8].exp_rgb)
            else value_error($sformatf("rgb %h after mid-frame reset", trk.rgb));

        if (err_cnt == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

// ==== verilog.f ====
logic/vga_timing_pkg.sv
logic/vga_color_pkg.sv
logic/vga_timing.sv
logic/vga_display.sv
logic/vga_pixel_pipe.sv
logic/vga_out.sv
logic/vga_colorbar_top.sv
dv/vga_colorbar_asserts.sv
dv/vga_colorbar_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the colour-bar testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

TOP=vga_colorbar_tb
BUILD_DIR=build
LOG=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -j 0 \
    --top-module "$TOP" \
    --Mdir "$BUILD_DIR" \
    -f verilog.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
fi

if [ $sim_status -eq 0 ] && grep -qx "All tests passed!" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
